/* source/fetch_pkg.sv */
package fetch_pkg;

  localparam int ADDR_WIDTH = 32;
  localparam int WORD_WIDTH = 32;

  // one read request on the address channel, len counts beats minus one
  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;
    logic [7:0]            len;
  } ar_req_t;

  // one beat on the read data channel
  typedef struct packed {
    logic [WORD_WIDTH-1:0] data;
    logic                  last;
  } r_beat_t;

  // instruction handed to decode together with its pc
  typedef struct packed {
    logic [ADDR_WIDTH-1:0] pc;
    logic [WORD_WIDTH-1:0] inst;
  } fetch_out_t;

  // what the sequencer asks the refill engine to fetch
  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;
    logic                  uncached;
  } refill_cmd_t;

  // number of 32-bit words in a line of 2^offset_bits bytes
  function automatic int line_words(int offset_bits);
    return (1 << offset_bits) / (WORD_WIDTH / 8);
  endfunction

  // tag width left over once offset and index are taken out of the address
  function automatic int tag_bits(int offset_bits, int index_bits);
    return ADDR_WIDTH - offset_bits - index_bits;
  endfunction

endpackage

/* source/icache_array.sv */
module icache_array #(
  parameter int OFFSET_BITS = 4,
  parameter int INDEX_BITS  = 2
) (
  input  logic                                         clock,
  input  logic                                         reset,
  input  logic                                         flush,
  input  logic [fetch_pkg::ADDR_WIDTH-1:0]             lookup_pc,
  output logic                                         hit,
  output logic [fetch_pkg::WORD_WIDTH-1:0]             hit_word,
  input  logic                                         fill_valid,
  input  logic [INDEX_BITS-1:0]                        fill_index,
  input  logic [fetch_pkg::tag_bits(OFFSET_BITS, INDEX_BITS)-1:0] fill_tag,
  input  logic [fetch_pkg::line_words(OFFSET_BITS)*fetch_pkg::WORD_WIDTH-1:0] fill_line
);
  import fetch_pkg::*;

  localparam int WORDS = line_words(OFFSET_BITS);
  localparam int TAG_W = tag_bits(OFFSET_BITS, INDEX_BITS);
  localparam int LINES = 1 << INDEX_BITS;

  logic [LINES-1:0]                  valid;
  logic [TAG_W-1:0]                  tags [LINES];
  logic [WORDS-1:0][WORD_WIDTH-1:0]  data [LINES];

  logic [INDEX_BITS-1:0]             index;
  logic [TAG_W-1:0]                  pc_tag;
  logic [OFFSET_BITS-1:0]            byte_off;
  logic [WORDS-1:0][WORD_WIDTH-1:0]  sel_line;

  assign index    = lookup_pc[OFFSET_BITS +: INDEX_BITS];
  assign pc_tag   = lookup_pc[ADDR_WIDTH-1 -: TAG_W];
  assign byte_off = lookup_pc[OFFSET_BITS-1:0];
  assign sel_line = data[index];

  assign hit      = valid[index] && (tags[index] == pc_tag);
  // word 0 sits in the low bits of the line
  assign hit_word = sel_line[byte_off >> 2];

  // flush wins over a fill landing in the same cycle
  always_ff @(posedge clock) begin
    if (reset || flush) begin
      valid <= '0;
    end else if (fill_valid) begin
      valid[fill_index] <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (fill_valid) begin
      tags[fill_index] <= fill_tag;
      data[fill_index] <= fill_line;
    end
  end

endmodule

/* source/line_refill.sv */
module line_refill #(
  parameter int OFFSET_BITS = 4,
  parameter int INDEX_BITS  = 2
) (
  input  logic                                         clock,
  input  logic                                         reset,
  input  logic                                         refill_start,
  input  fetch_pkg::refill_cmd_t                       refill_cmd,
  output logic                                         refill_busy,
  output logic                                         refill_done,
  output logic [fetch_pkg::WORD_WIDTH-1:0]             refill_word,
  output logic                                         ar_valid,
  output fetch_pkg::ar_req_t                           ar,
  input  logic                                         ar_ready,
  input  logic                                         r_valid,
  input  fetch_pkg::r_beat_t                           r,
  output logic                                         r_ready,
  output logic                                         fill_valid,
  output logic [INDEX_BITS-1:0]                        fill_index,
  output logic [fetch_pkg::tag_bits(OFFSET_BITS, INDEX_BITS)-1:0] fill_tag,
  output logic [fetch_pkg::line_words(OFFSET_BITS)*fetch_pkg::WORD_WIDTH-1:0] fill_line
);
  import fetch_pkg::*;

  localparam int WORDS  = line_words(OFFSET_BITS);
  localparam int TAG_W  = tag_bits(OFFSET_BITS, INDEX_BITS);
  localparam int LINE_W = WORDS * WORD_WIDTH;

  typedef enum logic [1:0] {
    S_IDLE,
    S_ADDR,
    S_DATA
  } state_t;

  state_t             state;
  refill_cmd_t        cmd_q;
  logic [LINE_W-1:0]  line_buf;
  logic [LINE_W-1:0]  line_next;
  logic               beat;
  logic               last_beat;

  assign beat        = r_valid && r_ready;
  assign last_beat   = beat && r.last;
  assign refill_busy = state != S_IDLE;

  // the sequencer already aligns cached addresses to the line
  assign ar_valid = state == S_ADDR;
  assign ar.addr  = cmd_q.addr;
  assign ar.len   = cmd_q.uncached ? 8'd0 : 8'(WORDS - 1);
  assign r_ready  = state == S_DATA;

  // each beat enters at the top so the first word ends up lowest
  assign line_next = LINE_W'({r.data, line_buf} >> WORD_WIDTH);

  // index and tag come from the command, so the line lands where it was asked for
  assign fill_valid = last_beat && !cmd_q.uncached;
  assign fill_index = cmd_q.addr[OFFSET_BITS +: INDEX_BITS];
  assign fill_tag   = cmd_q.addr[ADDR_WIDTH-1 -: TAG_W];
  assign fill_line  = line_next;

  always_ff @(posedge clock) begin
    if (reset) begin
      state       <= S_IDLE;
      refill_done <= 1'b0;
    end else begin
      refill_done <= last_beat;
      case (state)
        S_IDLE: if (refill_start) state <= S_ADDR;
        S_ADDR: if (ar_ready) state <= S_DATA;
        S_DATA: if (last_beat) state <= S_IDLE;
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == S_IDLE && refill_start) begin
      cmd_q <= refill_cmd;
    end
    if (beat) begin
      line_buf <= line_next;
      if (cmd_q.uncached) begin
        refill_word <= r.data;
      end
    end
  end

endmodule

/* source/fetch_sequencer.sv */
module fetch_sequencer #(
  parameter int                             OFFSET_BITS   = 4,
  parameter logic [fetch_pkg::ADDR_WIDTH-1:0] RESET_PC    = 32'h3000_0000,
  parameter logic [7:0]                     UNCACHED_CODE = 8'h0f
) (
  input  logic                             clock,
  input  logic                             reset,
  input  logic                             redirect,
  input  logic [fetch_pkg::ADDR_WIDTH-1:0] redirect_pc,
  input  logic                             hit,
  input  logic [fetch_pkg::WORD_WIDTH-1:0] hit_word,
  output logic [fetch_pkg::ADDR_WIDTH-1:0] lookup_pc,
  output logic                             refill_start,
  output fetch_pkg::refill_cmd_t           refill_cmd,
  input  logic                             refill_busy,
  input  logic                             refill_done,
  input  logic [fetch_pkg::WORD_WIDTH-1:0] refill_word,
  output logic                             inst_valid,
  output fetch_pkg::fetch_out_t            inst,
  input  logic                             inst_ready
);
  import fetch_pkg::*;

  typedef enum logic {
    S_RUN,
    S_WAIT
  } state_t;

  state_t                 state;
  logic [ADDR_WIDTH-1:0]  pc;
  logic                   stale;
  logic                   wait_uncached;
  logic                   uncached;
  logic                   can_load;
  logic                   cached_hit;
  logic                   take_hit;
  logic                   take_word;

  assign lookup_pc  = pc;
  assign uncached   = pc[ADDR_WIDTH-1 -: 8] == UNCACHED_CODE;
  assign cached_hit = hit && !uncached;

  // a new lookup only goes ahead when the output register can take a result
  assign can_load = !inst_valid || inst_ready;
  assign take_hit = state == S_RUN && can_load && !redirect && cached_hit;

  assign refill_start = state == S_RUN && can_load && !redirect && !cached_hit && !refill_busy;
  assign refill_cmd.addr = uncached ? pc : {pc[ADDR_WIDTH-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
  assign refill_cmd.uncached = uncached;

  // an uncached word that a redirect overtook is dropped here
  assign take_word = state == S_WAIT && refill_done && wait_uncached && !stale && !redirect;

  always_ff @(posedge clock) begin
    if (reset) begin
      state         <= S_RUN;
      pc            <= RESET_PC;
      inst_valid    <= 1'b0;
      stale         <= 1'b0;
      wait_uncached <= 1'b0;
    end else begin
      if (redirect) begin
        pc         <= redirect_pc;
        inst_valid <= 1'b0;
      end else if (take_hit || take_word) begin
        pc         <= pc + ADDR_WIDTH'(4);
        inst_valid <= 1'b1;
      end else if (inst_ready) begin
        inst_valid <= 1'b0;
      end

      case (state)
        S_RUN: begin
          if (refill_start) begin
            state         <= S_WAIT;
            wait_uncached <= uncached;
          end
        end
        S_WAIT: begin
          // a cached line is in the array now, so the lookup repeats and hits
          if (refill_done) state <= S_RUN;
        end
        default: state <= S_RUN;
      endcase

      // bursts cannot abort, so a redirect only marks the one in flight
      if (state == S_WAIT && refill_done) begin
        stale <= 1'b0;
      end else if (state == S_WAIT && redirect) begin
        stale <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (take_hit) begin
      inst.pc   <= pc;
      inst.inst <= hit_word;
    end else if (take_word) begin
      inst.pc   <= pc;
      inst.inst <= refill_word;
    end
  end

endmodule

/* source/fetch_unit.sv */
module fetch_unit #(
  parameter int                               OFFSET_BITS   = 4,
  parameter int                               INDEX_BITS    = 2,
  parameter logic [fetch_pkg::ADDR_WIDTH-1:0] RESET_PC      = 32'h3000_0000,
  parameter logic [7:0]                       UNCACHED_CODE = 8'h0f
) (
  input  logic                             clock,
  input  logic                             reset,
  input  logic                             redirect,
  input  logic [fetch_pkg::ADDR_WIDTH-1:0] redirect_pc,
  input  logic                             flush,
  output logic                             inst_valid,
  output fetch_pkg::fetch_out_t            inst,
  input  logic                             inst_ready,
  output logic                             ar_valid,
  output fetch_pkg::ar_req_t               ar,
  input  logic                             ar_ready,
  input  logic                             r_valid,
  input  fetch_pkg::r_beat_t               r,
  output logic                             r_ready
);
  import fetch_pkg::*;

  localparam int LINE_W = line_words(OFFSET_BITS) * WORD_WIDTH;
  localparam int TAG_W  = tag_bits(OFFSET_BITS, INDEX_BITS);

  logic [ADDR_WIDTH-1:0]  lookup_pc;
  logic                   hit;
  logic [WORD_WIDTH-1:0]  hit_word;
  logic                   refill_start;
  refill_cmd_t            refill_cmd;
  logic                   refill_busy;
  logic                   refill_done;
  logic [WORD_WIDTH-1:0]  refill_word;
  logic                   fill_valid;
  logic [INDEX_BITS-1:0]  fill_index;
  logic [TAG_W-1:0]       fill_tag;
  logic [LINE_W-1:0]      fill_line;

  icache_array #(
    .OFFSET_BITS(OFFSET_BITS),
    .INDEX_BITS (INDEX_BITS)
  ) u_array (
    .clock     (clock),
    .reset     (reset),
    .flush     (flush),
    .lookup_pc (lookup_pc),
    .hit       (hit),
    .hit_word  (hit_word),
    .fill_valid(fill_valid),
    .fill_index(fill_index),
    .fill_tag  (fill_tag),
    .fill_line (fill_line)
  );

  line_refill #(
    .OFFSET_BITS(OFFSET_BITS),
    .INDEX_BITS (INDEX_BITS)
  ) u_refill (
    .clock       (clock),
    .reset       (reset),
    .refill_start(refill_start),
    .refill_cmd  (refill_cmd),
    .refill_busy (refill_busy),
    .refill_done (refill_done),
    .refill_word (refill_word),
    .ar_valid    (ar_valid),
    .ar          (ar),
    .ar_ready    (ar_ready),
    .r_valid     (r_valid),
    .r           (r),
    .r_ready     (r_ready),
    .fill_valid  (fill_valid),
    .fill_index  (fill_index),
    .fill_tag    (fill_tag),
    .fill_line   (fill_line)
  );

  fetch_sequencer #(
    .OFFSET_BITS  (OFFSET_BITS),
    .RESET_PC     (RESET_PC),
    .UNCACHED_CODE(UNCACHED_CODE)
  ) u_sequencer (
    .clock       (clock),
    .reset       (reset),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .hit         (hit),
    .hit_word    (hit_word),
    .lookup_pc   (lookup_pc),
    .refill_start(refill_start),
    .refill_cmd  (refill_cmd),
    .refill_busy (refill_busy),
    .refill_done (refill_done),
    .refill_word (refill_word),
    .inst_valid  (inst_valid),
    .inst        (inst),
    .inst_ready  (inst_ready)
  );

endmodule

/* test/fetch_asserts.sv */
module fetch_asserts (
  input logic                  clock,
  input logic                  reset,
  input logic                  redirect,
  input logic                  inst_valid,
  input logic                  inst_ready,
  input fetch_pkg::fetch_out_t inst,
  input logic                  ar_valid,
  input logic                  ar_ready,
  input fetch_pkg::ar_req_t    ar,
  input logic                  r_valid,
  input logic                  r_ready,
  input fetch_pkg::r_beat_t    r
);
  logic burst_open;

  // open from the address transfer until the last beat of that burst
  always_ff @(posedge clock) begin
    if (reset) begin
      burst_open <= 1'b0;
    end else if (ar_valid && ar_ready) begin
      burst_open <= 1'b1;
    end else if (r_valid && r_ready && r.last) begin
      burst_open <= 1'b0;
    end
  end

  ar_hold: assert property (@(posedge clock) disable iff (reset)
    ar_valid && !ar_ready |=> ar_valid && $stable(ar))
    else $error("read request changed or dropped before its transfer");

  inst_hold: assert property (@(posedge clock) disable iff (reset)
    inst_valid && !inst_ready && !redirect |=> inst_valid && $stable(inst))
    else $error("instruction changed or dropped while decode stalled");

  one_burst: assert property (@(posedge clock) disable iff (reset)
    burst_open |-> !ar_valid)
    else $error("second read request before the last beat of the burst");

  redirect_drop: assert property (@(posedge clock) disable iff (reset)
    redirect |=> !inst_valid)
    else $error("instruction still valid the cycle after a redirect");

endmodule

bind fetch_unit fetch_asserts u_asserts (.*);

/* test/fetch_tb.sv */
module fetch_tb;
  import fetch_pkg::*;

  localparam int          OFFSET_BITS   = 4;
  localparam int          INDEX_BITS    = 2;
  localparam logic [31:0] RESET_PC      = 32'h3000_0000;
  localparam logic [7:0]  UNCACHED_CODE = 8'h0f;
  localparam int          WORDS         = (1 << OFFSET_BITS) / 4;
  localparam int          TAG_W         = 32 - OFFSET_BITS - INDEX_BITS;
  localparam int          LINES         = 1 << INDEX_BITS;
  localparam int          N_INSTS       = 400;
  // a full line refill with every handshake stalled, plus decode stalls on top
  localparam int          WORST_CYCLES  = 64;
  localparam int          TIMEOUT       = (N_INSTS * WORST_CYCLES + 8) * 8;

  logic        clock, reset, redirect, flush;
  logic [31:0] redirect_pc;
  logic        inst_valid, inst_ready, ar_valid, ar_ready, r_valid, r_ready;
  fetch_out_t  inst;
  ar_req_t     ar;
  r_beat_t     r;

  // reference model state
  logic [31:0]      accept_pc, fetch_pc, last_unc_addr, cur_addr;
  logic [LINES-1:0] sh_valid;
  logic [TAG_W-1:0] sh_tag [LINES];
  r_beat_t          beats [$];
  logic             load_next, r_taken, pend_flush, pend_fill, ar_seen, in_burst;
  int               accepted, fetch_errors, request_errors, flag_errors, other_errors;

  fetch_unit #(.OFFSET_BITS(OFFSET_BITS), .INDEX_BITS(INDEX_BITS),
               .RESET_PC(RESET_PC), .UNCACHED_CODE(UNCACHED_CODE)) DUT (.*);

  always #4 clock = ~clock;

  function automatic logic [31:0] mem_word(logic [31:0] addr);
    return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]} ^ 32'h5a5a_c3c3;
  endfunction

  function automatic logic is_uncached(logic [31:0] addr);
    return addr[31:24] == UNCACHED_CODE;
  endfunction

  function automatic logic line_held(logic [31:0] addr);
    return sh_valid[addr[OFFSET_BITS +: INDEX_BITS]] &&
           sh_tag[addr[OFFSET_BITS +: INDEX_BITS]] == addr[31 -: TAG_W];
  endfunction

  task automatic check_fetch(input string name, input fetch_out_t got, input fetch_out_t exp);
    if (got !== exp) begin
      fetch_errors++;
      $display("ERR %s pc %h inst %h, expected pc %h inst %h",
               name, got.pc, got.inst, exp.pc, exp.inst);
    end
  endtask

  task automatic check_request(input string name, input ar_req_t got, input ar_req_t exp);
    if (got !== exp) begin
      request_errors++;
      $display("ERR %s addr %h len %h, expected addr %h len %h",
               name, got.addr, got.len, exp.addr, exp.len);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      flag_errors++;
      $display("ERR %s %h, expected %h", name, got, exp);
    end
  endtask

  // one falling edge: settle what the last rising edge did, then drive the next one
  task automatic step();
    fetch_out_t exp_f;
    ar_req_t    exp_r;
    // the data channel is ready exactly while a burst is open
    check_flag("r_ready", r_ready, in_burst);
    if (load_next && inst_valid) begin
      exp_f = {fetch_pc, mem_word(fetch_pc)};
      check_fetch("inst loaded", inst, exp_f);
      if (is_uncached(fetch_pc) && last_unc_addr != fetch_pc) begin
        other_errors++;
        $display("uncached instruction at %h was delivered without its own read", fetch_pc);
      end else if (!is_uncached(fetch_pc) && !line_held(fetch_pc)) begin
        other_errors++;
        $display("instruction at %h came from a line the cache does not hold", fetch_pc);
      end
      fetch_pc = fetch_pc + 32'd4;
    end
    // flush wins over a fill on the same edge
    if (pend_flush) begin
      sh_valid = '0;
    end else if (pend_fill) begin
      sh_valid[cur_addr[OFFSET_BITS +: INDEX_BITS]] = 1'b1;
      sh_tag[cur_addr[OFFSET_BITS +: INDEX_BITS]] = cur_addr[31 -: TAG_W];
    end
    if (r_taken) begin
      beats.delete(0);
      r_valid = 1'b0;
    end
    if (ar_valid && !ar_seen) begin
      exp_r.addr = is_uncached(fetch_pc) ? fetch_pc : fetch_pc & ~32'((1 << OFFSET_BITS) - 1);
      exp_r.len  = is_uncached(fetch_pc) ? 8'd0 : 8'(WORDS - 1);
      check_request("ar", ar, exp_r);
    end
    ar_seen = ar_valid;

    inst_ready = ($urandom % 4) != 0;
    flush      = ($urandom % 64) == 0;
    redirect   = ($urandom % 32) == 0;
    if (($urandom % 3) == 0) begin
      redirect_pc = {UNCACHED_CODE, 24'(($urandom % 16) * 4)};
    end else begin
      redirect_pc = RESET_PC + 32'(($urandom % 64) * 4);
    end
    ar_ready = ($urandom % 3) != 0;
    if (!r_valid && beats.size() != 0 && ($urandom % 3) != 0) begin
      r_valid = 1'b1;
      r       = beats[0];
    end

    if (inst_valid && inst_ready) begin
      exp_f = {accept_pc, mem_word(accept_pc)};
      check_fetch("inst", inst, exp_f);
      accept_pc = accept_pc + 32'd4;
      accepted++;
    end
    if (ar_valid && ar_ready) begin
      if (!is_uncached(ar.addr) && line_held(ar.addr)) begin
        other_errors++;
        $display("read request for %h although the cache holds that line", ar.addr);
      end
      if (is_uncached(ar.addr)) last_unc_addr = ar.addr;
      cur_addr = ar.addr;
      in_burst = 1'b1;
      for (int i = 0; i <= int'(ar.len); i++) begin
        beats.push_back({mem_word(ar.addr + 32'(4 * i)), i == int'(ar.len)});
      end
    end
    r_taken    = r_valid && r_ready;
    pend_fill  = r_taken && r.last && !is_uncached(cur_addr);
    pend_flush = flush;
    if (r_taken && r.last) begin
      in_burst = 1'b0;
    end
    if (redirect) begin
      accept_pc = redirect_pc;
      fetch_pc  = redirect_pc;
    end
    load_next = (!inst_valid || inst_ready) && !redirect;
  endtask

  initial begin
    void'($urandom(32'h3521117b));
    clock = 1'b0;
    reset = 1'b1;
    redirect = 1'b0;
    redirect_pc = '0;
    flush = 1'b0;
    inst_ready = 1'b0;
    ar_ready = 1'b0;
    r_valid = 1'b0;
    r = '0;
    accept_pc = RESET_PC;
    fetch_pc = RESET_PC;
    last_unc_addr = '0;
    cur_addr = '0;
    sh_valid = '0;
    {load_next, r_taken, pend_flush, pend_fill, ar_seen, in_burst} = '0;
    {accepted, fetch_errors, request_errors, flag_errors, other_errors} = '0;
    repeat (5) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    while (accepted < N_INSTS) begin
      step();
      @(negedge clock);
    end
    $display("errors: fetch %0d, request %0d, flag %0d, other %0d",
             fetch_errors, request_errors, flag_errors, other_errors);
    if (fetch_errors + request_errors + flag_errors + other_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT);
    $display("timeout after %0d accepted instructions, the fetch unit stopped", accepted);
    $display(">>> FAIL");
    $finish;
  end

endmodule

/* verilog.f */
source/fetch_pkg.sv
source/icache_array.sv
source/line_refill.sv
source/fetch_sequencer.sv
source/fetch_unit.sv
test/fetch_asserts.sv
test/fetch_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module fetch_tb -f verilog.f -o fetch_sim
./obj_dir/fetch_sim | tee sim.log

if grep -q '^>>> PASS$' sim.log; then
  exit 0
fi
echo "simulation failed, see sim.log"
exit 1
